// File: design/sd_cmd_config.svh
// SD command line configuration: frame sizes, counter width and response timeout
`ifndef SD_CMD_CONFIG_SVH
`define SD_CMD_CONFIG_SVH

// transmitted frame, command word plus end byte
`define CMD_FRAME_BITS 48

// response lengths, start bit included
`define RESP_LONG_BITS 136
`define RESP_SHORT_BITS 48

// bit counters, wide enough for the long response
`define FRAME_CNT_BITS 8

// sd_clock cycles allowed for the card's start bit after turnaround
`define NCR_TIMEOUT 64

// trailing byte appended to every command
`define END_BYTE 8'h01

`endif

// File: design/sd_cmd_pkg.sv
// SD command line types shared by the physical layer blocks
`default_nettype none

`include "sd_cmd_config.svh"

package sd_cmd_pkg;

	// host command, start and direction bits included
	typedef logic [`CMD_FRAME_BITS-9:0] cmd_word_t;

	// command word with the end byte appended
	typedef logic [`CMD_FRAME_BITS-1:0] cmd_frame_t;

	// response, short ones right-aligned
	typedef logic [`RESP_LONG_BITS-1:0] resp_word_t;

	// frame length or bit count
	typedef logic [`FRAME_CNT_BITS-1:0] frame_len_t;

	// command index, bits 37 to 32 of the command word
	typedef logic [5:0] cmd_index_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SEND,
		ST_TURN,
		ST_WAIT_RESP,
		ST_DONE,
		ST_TIMEOUT
	} cmd_state_t;

endpackage

`default_nettype wire

// File: design/cmd_pad.sv
// Command pad: tristate driver on the CMD line with a registered input sample
`timescale 1ns/1ps
`default_nettype none

module cmd_pad (
	input logic sd_clock,
	input logic rst,
	input logic drive,
	input logic enable,
	input logic data_in,
	output logic data_out,
	inout wire io_port
);

	// host drives only while sending, card owns the line otherwise
	assign io_port = drive ? data_in : 1'bz;

	// sampled pin, idle level when not listening
	always_ff @(posedge sd_clock) begin
		if (rst) begin
			data_out <= 1'b1;
		end else if (enable) begin
			data_out <= io_port;
		end else begin
			data_out <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/cmd_serializer.sv
// Command serializer: shifts the 48-bit command frame out MSB first
`timescale 1ns/1ps
`default_nettype none

`include "sd_cmd_config.svh"

module cmd_serializer
	import sd_cmd_pkg::*;
(
	input logic sd_clock,
	input logic rst,
	input logic clear,
	input logic enable,
	input logic load_send,
	input cmd_frame_t parallel,
	output logic serial,
	output logic complete
);

	cmd_frame_t shift_reg;
	frame_len_t bit_cnt;

	// frame register loaded by load_send and shifted MSB first
	always_ff @(posedge sd_clock) begin
		if (load_send) begin
			shift_reg <= parallel;
		end else if (enable) begin
			shift_reg <= {shift_reg[`CMD_FRAME_BITS-2:0], 1'b1};
		end
	end

	// bits already sent
	always_ff @(posedge sd_clock) begin
		if (rst || clear || load_send) begin
			bit_cnt <= '0;
		end else if (enable) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// line idles high between frames
	assign serial = enable ? shift_reg[`CMD_FRAME_BITS-1] : 1'b1;

	// high together with the last bit on the line
	assign complete = enable && (bit_cnt == frame_len_t'(`CMD_FRAME_BITS - 1));

endmodule

`default_nettype wire

// File: design/cmd_deserializer.sv
// Command deserializer: hunts for the start bit and collects a response frame
`timescale 1ns/1ps
`default_nettype none

module cmd_deserializer
	import sd_cmd_pkg::*;
(
	input logic sd_clock,
	input logic rst,
	input logic clear,
	input logic enable,
	input frame_len_t framesize,
	input logic serial,
	output resp_word_t parallel,
	output logic start_seen,
	output logic complete
);

	frame_len_t bit_cnt;
	logic receiving;
	logic last_bit;

	// this sample fills the frame
	assign last_bit = receiving && ((bit_cnt + 1'b1) == framesize);

	// start_seen stays up after the frame so the hunt does not re-arm
	always_ff @(posedge sd_clock) begin
		if (rst || clear) begin
			start_seen <= 1'b0;
			receiving <= 1'b0;
			bit_cnt <= '0;
			complete <= 1'b0;
		end else begin
			complete <= 1'b0;
			if (enable) begin
				if (!start_seen && !serial) begin
					start_seen <= 1'b1;
					receiving <= 1'b1;
					bit_cnt <= frame_len_t'(1);
				end else if (receiving) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (last_bit) begin
						receiving <= 1'b0;
						complete <= 1'b1;
					end
				end
			end
		end
	end

	// payload; the start bit enters a zeroed register, so the result is right-aligned
	always_ff @(posedge sd_clock) begin
		if (enable) begin
			if (!start_seen && !serial) begin
				parallel <= resp_word_t'(serial);
			end else if (receiving) begin
				parallel <= {parallel[$bits(resp_word_t)-2:0], serial};
			end
		end
	end

endmodule

`default_nettype wire

// File: design/cmd_phys_controller.sv
// Command line controller: sequences send, turnaround, receive and host handover
`timescale 1ns/1ps
`default_nettype none

`include "sd_cmd_config.svh"

module cmd_phys_controller
	import sd_cmd_pkg::*;
(
	input logic sd_clock,
	input logic rst,
	input logic strobe_in,
	input logic ack_in,
	input logic idle_in,
	input logic timeout_enable,
	input logic transmission_complete,
	input logic reception_complete,
	input logic start_seen,
	input resp_word_t pad_response,
	output logic ack_out,
	output logic strobe_out,
	output logic COMMAND_TIMEOUT,
	output logic load_send,
	output logic shifter_clear,
	output logic enable_pts,
	output logic enable_stp,
	output logic pad_drive,
	output logic pad_enable,
	output resp_word_t response
);

	cmd_state_t state;
	cmd_state_t state_next;
	frame_len_t wait_cnt;
	logic timeout_en_q;
	logic wait_expired;
	logic take_cmd;

	// new command accepted this cycle
	assign take_cmd = (state == ST_IDLE) && strobe_in;

	// no start bit within the NCR window
	assign wait_expired = timeout_en_q && !start_seen
		&& (wait_cnt == frame_len_t'(`NCR_TIMEOUT - 1));

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (strobe_in) begin
					state_next = ST_LOAD;
				end
			end
			ST_LOAD: begin
				state_next = ST_SEND;
			end
			ST_SEND: begin
				if (transmission_complete) begin
					state_next = ST_TURN;
				end
			end
			ST_TURN: begin
				state_next = ST_WAIT_RESP;
			end
			ST_WAIT_RESP: begin
				if (reception_complete) begin
					state_next = ST_DONE;
				end else if (wait_expired) begin
					state_next = ST_TIMEOUT;
				end
			end
			ST_DONE, ST_TIMEOUT: begin
				if (ack_in) begin
					state_next = ST_IDLE;
				end
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
		// host abort wins over everything
		if (idle_in) begin
			state_next = ST_IDLE;
		end
	end

	always_ff @(posedge sd_clock) begin
		if (rst) begin
			state <= ST_IDLE;
			ack_out <= 1'b0;
			strobe_out <= 1'b0;
			COMMAND_TIMEOUT <= 1'b0;
			timeout_en_q <= 1'b0;
			wait_cnt <= '0;
			response <= '0;
		end else begin
			state <= state_next;
			ack_out <= take_cmd && !idle_in;
			// flags follow the handover states, so ack_in drops them a cycle later
			strobe_out <= (state_next == ST_DONE);
			COMMAND_TIMEOUT <= (state_next == ST_TIMEOUT);
			if (take_cmd) begin
				timeout_en_q <= timeout_enable;
			end
			// counts only while listening for the start bit
			if (state != ST_WAIT_RESP) begin
				wait_cnt <= '0;
			end else if (!start_seen) begin
				wait_cnt <= wait_cnt + 1'b1;
			end
			if ((state == ST_WAIT_RESP) && reception_complete && !idle_in) begin
				response <= pad_response;
			end
		end
	end

	// shifter and pad controls decoded from the state register
	assign load_send = (state == ST_LOAD);
	assign shifter_clear = (state == ST_LOAD) || (state == ST_TURN);
	assign enable_pts = (state == ST_SEND);
	assign enable_stp = (state == ST_WAIT_RESP);
	assign pad_drive = (state == ST_SEND);
	// sampling starts at turnaround so the first card bit is not lost
	assign pad_enable = (state == ST_TURN) || (state == ST_WAIT_RESP);

endmodule

`default_nettype wire

// File: design/cmd_phys.sv
// Command line physical layer top: frame build, response length select and datapath
`timescale 1ns/1ps
`default_nettype none

`include "sd_cmd_config.svh"

module cmd_phys
	import sd_cmd_pkg::*;
(
	input logic sd_clock,
	input logic rst,
	input logic strobe_in,
	input logic ack_in,
	input logic idle_in,
	input cmd_word_t cmd_to_send,
	input logic TIMEOUT_ENABLE,
	output logic ack_out,
	output logic strobe_out,
	output resp_word_t response,
	inout wire cmd_pin,
	output logic COMMAND_TIMEOUT
);

	cmd_word_t cmd_q;
	cmd_frame_t frame;
	cmd_index_t cmd_index;
	frame_len_t framesize_reception;
	resp_word_t pad_response;
	logic transmission_complete;
	logic reception_complete;
	logic start_seen;
	logic load_send;
	logic shifter_clear;
	logic enable_pts;
	logic enable_stp;
	logic pad_drive;
	logic pad_enable;
	logic serial_pad;
	logic pad_serial;

	// command held from the strobe for the whole transaction
	always_ff @(posedge sd_clock) begin
		if (strobe_in) begin
			cmd_q <= cmd_to_send;
		end
	end

	assign frame = {cmd_q, `END_BYTE};
	assign cmd_index = cmd_q[37:32];

	// CMD2, CMD9 and CMD10 answer with the long R2 format
	always_comb begin
		if ((cmd_index == 6'd2) || (cmd_index == 6'd9) || (cmd_index == 6'd10)) begin
			framesize_reception = frame_len_t'(`RESP_LONG_BITS);
		end else begin
			framesize_reception = frame_len_t'(`RESP_SHORT_BITS);
		end
	end

	cmd_serializer u_serializer (
		.sd_clock (sd_clock),
		.rst (rst),
		.clear (shifter_clear),
		.enable (enable_pts),
		.load_send (load_send),
		.parallel (frame),
		.serial (serial_pad),
		.complete (transmission_complete)
	);

	cmd_deserializer u_deserializer (
		.sd_clock (sd_clock),
		.rst (rst),
		.clear (shifter_clear),
		.enable (enable_stp),
		.framesize (framesize_reception),
		.serial (pad_serial),
		.parallel (pad_response),
		.start_seen (start_seen),
		.complete (reception_complete)
	);

	cmd_pad u_pad (
		.sd_clock (sd_clock),
		.rst (rst),
		.drive (pad_drive),
		.enable (pad_enable),
		.data_in (serial_pad),
		.data_out (pad_serial),
		.io_port (cmd_pin)
	);

	cmd_phys_controller u_controller (
		.sd_clock (sd_clock),
		.rst (rst),
		.strobe_in (strobe_in),
		.ack_in (ack_in),
		.idle_in (idle_in),
		.timeout_enable (TIMEOUT_ENABLE),
		.transmission_complete (transmission_complete),
		.reception_complete (reception_complete),
		.start_seen (start_seen),
		.pad_response (pad_response),
		.ack_out (ack_out),
		.strobe_out (strobe_out),
		.COMMAND_TIMEOUT (COMMAND_TIMEOUT),
		.load_send (load_send),
		.shifter_clear (shifter_clear),
		.enable_pts (enable_pts),
		.enable_stp (enable_stp),
		.pad_drive (pad_drive),
		.pad_enable (pad_enable),
		.response (response)
	);

endmodule

`default_nettype wire

// File: sim/sd_card_model.sv
// SD card model: captures the command frame and answers after a delay
`timescale 1ns/1ps
`default_nettype none

`include "sd_cmd_config.svh"

module sd_card_model
	import sd_cmd_pkg::*;
(
	input logic sd_clock,
	input logic rst,
	inout wire cmd_pin,
	input logic respond,
	input int delay,
	input int resp_len,
	input resp_word_t payload,
	output cmd_frame_t frame,
	output logic frame_valid
);

	logic drive_en;
	logic drive_val;
	cmd_frame_t shift;
	int i;

	assign cmd_pin = drive_en ? drive_val : 1'bz;

	initial begin
		drive_en = 1'b0;
		drive_val = 1'b1;
		frame = '0;
		frame_valid = 1'b0;
	end

	// hunt for the host start bit, then take the rest of the frame
	always begin
		@(posedge sd_clock);
		if (!rst && !drive_en && cmd_pin === 1'b0) begin
			shift = '0;
			for (i = 1; i < `CMD_FRAME_BITS; i++) begin
				@(posedge sd_clock);
				shift = {shift[`CMD_FRAME_BITS-2:0], cmd_pin};
			end
			frame <= shift;
			frame_valid <= 1'b1;
			@(posedge sd_clock);
			frame_valid <= 1'b0;
			if (respond) begin
				repeat (delay) @(posedge sd_clock);
				// response bits change on the falling edge, MSB first
				for (i = resp_len - 1; i >= 0; i--) begin
					@(negedge sd_clock);
					drive_en = 1'b1;
					drive_val = payload[i];
				end
				@(negedge sd_clock);
				drive_en = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/cmd_phys_monitor.sv
// Monitor: compares DUT ports and card captures against the expected values
`timescale 1ns/1ps
`default_nettype none

`include "sd_cmd_config.svh"

module cmd_phys_monitor
	import sd_cmd_pkg::*;
(
	input logic sd_clock,
	input logic rst,
	input logic strobe_in,
	input logic ack_in,
	input logic idle_in,
	input logic ack_out,
	input logic strobe_out,
	input logic cmd_timeout,
	input resp_word_t response,
	input logic cmd_pin,
	input cmd_frame_t card_frame,
	input logic card_frame_valid,
	input cmd_frame_t exp_frame,
	input resp_word_t exp_resp,
	input logic [1:0] exp_kind,
	input logic test_end,
	input logic run_end,
	input int test_num,
	input cmd_index_t test_index,
	output int error_count
);

	int cycles;
	int test_errors;
	int passed;
	int failed;
	logic strobe_q;
	logic so_q;
	logic to_q;
	logic ack_q;
	logic idle_q;
	logic got_frame;
	logic got_event;
	logic reset_checked;
	resp_word_t held;

	initial begin
		error_count = 0;
		test_errors = 0;
		passed = 0;
		failed = 0;
		cycles = 0;
		strobe_q = 1'b0;
		so_q = 1'b0;
		to_q = 1'b0;
		ack_q = 1'b0;
		idle_q = 1'b0;
		got_frame = 1'b0;
		got_event = 1'b0;
		reset_checked = 1'b0;
		held = '0;
	end

	task automatic check_value(input string name, input resp_word_t got, input resp_word_t exp);
		if (got !== exp) begin
			$display("[FAIL] time %0t: %s = %0h, expected %0h", $time, name, got, exp);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("time %0t: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	// exp_kind: 0 response, 1 timeout, 2 neither
	always @(posedge sd_clock) begin
		if (!rst) begin
			if (!reset_checked) begin
				check_value("ack_out", ack_out, 0);
				check_value("strobe_out", strobe_out, 0);
				check_value("COMMAND_TIMEOUT", cmd_timeout, 0);
				check_value("response", response, 0);
				check_value("cmd_pin", cmd_pin, 1);
				reset_checked = 1'b1;
			end
			cycles++;
			check_value("ack_out", ack_out, strobe_q);
			if (card_frame_valid) begin
				got_frame = 1'b1;
				check_value("card frame", card_frame, exp_frame);
				if (cycles != 2 + `CMD_FRAME_BITS)
					report_problem("command frame did not start 2 cycles after strobe_in");
			end
			if (strobe_out && !so_q) begin
				got_event = 1'b1;
				if (exp_kind != 2'd0)
					report_problem("strobe_out rose although no response was expected");
				check_value("response", response, exp_resp);
				held = response;
			end
			if (cmd_timeout && !to_q) begin
				got_event = 1'b1;
				if (exp_kind != 2'd1)
					report_problem("COMMAND_TIMEOUT rose although no timeout was expected");
				if (cycles < 2 + `CMD_FRAME_BITS + `NCR_TIMEOUT)
					report_problem("COMMAND_TIMEOUT rose before the window ended");
			end
			// back-pressure: flags and response hold until ack_in
			if (so_q && !ack_q && !idle_q) begin
				check_value("strobe_out", strobe_out, 1);
				check_value("response", response, held);
			end
			if (to_q && !ack_q && !idle_q)
				check_value("COMMAND_TIMEOUT", cmd_timeout, 1);
			if ((so_q || to_q) && ack_q) begin
				check_value("strobe_out", strobe_out, 0);
				check_value("COMMAND_TIMEOUT", cmd_timeout, 0);
			end
			if (test_end) begin
				if (!got_frame)
					report_problem("no command frame reached the card");
				if (exp_kind != 2'd2 && !got_event)
					report_problem("neither a response nor a timeout was flagged");
				if (test_errors == 0) begin
					passed++;
					$display("test %0d (CMD%0d): passed", test_num, test_index);
				end else begin
					failed++;
					$display("test %0d (CMD%0d): failed", test_num, test_index);
				end
				test_errors = 0;
				got_frame = 1'b0;
				got_event = 1'b0;
			end
			if (run_end)
				$display("tests: %0d passed, %0d failed, %0d errors", passed, failed, error_count);
			if (strobe_in)
				cycles = 0;
		end
		strobe_q = strobe_in && !rst;
		so_q = strobe_out;
		to_q = cmd_timeout;
		ack_q = ack_in;
		idle_q = idle_in;
	end

endmodule

`default_nettype wire

// File: sim/cmd_phys_chk.sv
// Assertions on the controller handshake and pad direction
`timescale 1ns/1ps
`default_nettype none

`include "sd_cmd_config.svh"

module cmd_phys_chk (
	input logic sd_clock,
	input logic rst,
	input logic ack_in,
	input logic idle_in,
	input logic ack_out,
	input logic strobe_out,
	input logic COMMAND_TIMEOUT,
	input logic pad_drive
);

	ack_single: assert property (@(posedge sd_clock) disable iff (rst) ack_out |=> !ack_out)
		else $error("ack_out lasted more than one cycle");

	// host drives the pin for exactly one command frame
	frame_drive_len: assert property (@(posedge sd_clock) disable iff (rst)
		$fell(pad_drive) && !$past(idle_in)
		|-> $past(pad_drive, `CMD_FRAME_BITS) && !$past(pad_drive, `CMD_FRAME_BITS + 1))
		else $error("pad_drive did not last one command frame");

	// timeout flag waits for the host like strobe_out
	timeout_held: assert property (@(posedge sd_clock) disable iff (rst)
		COMMAND_TIMEOUT && !ack_in && !idle_in |=> COMMAND_TIMEOUT)
		else $error("COMMAND_TIMEOUT fell before ack_in");

	strobe_held: assert property (@(posedge sd_clock) disable iff (rst)
		strobe_out && !ack_in && !idle_in |=> strobe_out)
		else $error("strobe_out fell before ack_in");

endmodule

bind cmd_phys_controller cmd_phys_chk u_chk (.*);

`default_nettype wire

// File: sim/cmd_phys_tb.sv
// Testbench for the SD command line physical layer
`timescale 1ns/1ps
`default_nettype none

`include "sd_cmd_config.svh"

module cmd_phys_tb
	import sd_cmd_pkg::*;
();

	typedef struct packed {
		cmd_index_t idx;
		logic te;
		logic answers;
		logic [7:0] delay;
		logic [7:0] ack_wait;
	} row_t;

	localparam int N_ROWS = 8;

	row_t rows [N_ROWS];
	logic sd_clock;
	logic rst;
	logic strobe_in;
	logic ack_in;
	logic idle_in;
	cmd_word_t cmd_to_send;
	logic timeout_enable;
	logic ack_out;
	logic strobe_out;
	logic command_timeout;
	resp_word_t response;
	tri1 cmd_pin;
	logic respond;
	int card_delay;
	int resp_len;
	resp_word_t payload;
	cmd_frame_t card_frame;
	logic card_frame_valid;
	cmd_frame_t exp_frame;
	resp_word_t exp_resp;
	logic [1:0] exp_kind;
	logic test_end;
	logic run_end;
	int test_num;
	cmd_index_t test_index;
	int error_count;
	int cycle_count;
	int cycle_limit;
	logic [15:0] lfsr_state;

	cmd_phys u_cmd_phys (
		.sd_clock (sd_clock),
		.rst (rst),
		.strobe_in (strobe_in),
		.ack_in (ack_in),
		.idle_in (idle_in),
		.cmd_to_send (cmd_to_send),
		.TIMEOUT_ENABLE (timeout_enable),
		.ack_out (ack_out),
		.strobe_out (strobe_out),
		.response (response),
		.cmd_pin (cmd_pin),
		.COMMAND_TIMEOUT (command_timeout)
	);

	sd_card_model u_card (
		.sd_clock (sd_clock), .rst (rst), .cmd_pin (cmd_pin), .respond (respond),
		.delay (card_delay), .resp_len (resp_len), .payload (payload),
		.frame (card_frame), .frame_valid (card_frame_valid)
	);

	cmd_phys_monitor u_monitor (
		.sd_clock (sd_clock), .rst (rst), .strobe_in (strobe_in), .ack_in (ack_in),
		.idle_in (idle_in), .ack_out (ack_out), .strobe_out (strobe_out),
		.cmd_timeout (command_timeout), .response (response), .cmd_pin (cmd_pin),
		.card_frame (card_frame), .card_frame_valid (card_frame_valid),
		.exp_frame (exp_frame), .exp_resp (exp_resp), .exp_kind (exp_kind),
		.test_end (test_end), .run_end (run_end), .test_num (test_num),
		.test_index (test_index), .error_count (error_count)
	);

	always #50 sd_clock = ~sd_clock;

	// Galois LFSR, one step per random bit
	function automatic logic take_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b)
			lfsr_state = lfsr_state ^ 16'hB400;
		return b;
	endfunction

	function automatic resp_word_t random_bits(input int n);
		resp_word_t v;
		v = '0;
		for (int k = 0; k < n; k++)
			v = {v[$bits(resp_word_t)-2:0], take_bit()};
		return v;
	endfunction

	// R2 commands answer with the long format
	function automatic logic is_long(input cmd_index_t i);
		return (i == 6'd2) || (i == 6'd9) || (i == 6'd10);
	endfunction

	always @(posedge sd_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("run stopped after %0d cycles without finishing", cycle_count);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		cmd_word_t cmd;
		resp_word_t arg;
		int len;
		sd_clock = 1'b0;
		rst = 1'b1;
		strobe_in = 1'b0;
		ack_in = 1'b0;
		idle_in = 1'b0;
		cmd_to_send = '0;
		timeout_enable = 1'b0;
		respond = 1'b0;
		card_delay = 0;
		resp_len = `RESP_SHORT_BITS;
		payload = '0;
		exp_frame = '0;
		exp_resp = '0;
		exp_kind = 2'd0;
		test_end = 1'b0;
		run_end = 1'b0;
		test_num = 0;
		test_index = '0;
		cycle_count = 0;
		cycle_limit = 0;
		lfsr_state = 16'd11;
		// index, timeout enable, card answers, card delay, ack wait
		rows[0] = '{6'd17, 1'b1, 1'b1, 8'd3, 8'd0};
		rows[1] = '{6'd2, 1'b1, 1'b1, 8'd5, 8'd4};
		rows[2] = '{6'd9, 1'b0, 1'b1, 8'd10, 8'd2};
		rows[3] = '{6'd10, 1'b1, 1'b1, 8'd1, 8'd7};
		rows[4] = '{6'd55, 1'b1, 1'b0, 8'd0, 8'd3};
		rows[5] = '{6'd8, 1'b0, 1'b0, 8'd0, 8'd0};
		rows[6] = '{6'd13, 1'b1, 1'b1, 8'd20, 8'd5};
		rows[7] = '{6'd41, 1'b0, 1'b1, 8'd0, 8'd1};
		len = 16 + N_ROWS * (`NCR_TIMEOUT + 40);
		for (int r = 0; r < N_ROWS; r++)
			len += 48 + rows[r].delay + 136 + rows[r].ack_wait;
		cycle_limit = len;
		repeat (16) @(negedge sd_clock);
		rst = 1'b0;
		repeat (4) @(negedge sd_clock);
		for (int r = 0; r < N_ROWS; r++) begin
			len = is_long(rows[r].idx) ? `RESP_LONG_BITS : `RESP_SHORT_BITS;
			arg = random_bits(32);
			cmd = {2'b01, rows[r].idx, arg[31:0]};
			arg = random_bits(len);
			arg[len-1] = 1'b0;
			arg[0] = 1'b1;
			exp_frame = {cmd, 8'h01};
			exp_resp = arg;
			exp_kind = rows[r].answers ? 2'd0 : (rows[r].te ? 2'd1 : 2'd2);
			test_num = r;
			test_index = rows[r].idx;
			payload = arg;
			resp_len = len;
			card_delay = rows[r].delay;
			respond = rows[r].answers;
			cmd_to_send = cmd;
			timeout_enable = rows[r].te;
			strobe_in = 1'b1;
			@(negedge sd_clock);
			strobe_in = 1'b0;
			if (exp_kind != 2'd2) begin
				while (!(strobe_out || command_timeout))
					@(negedge sd_clock);
				repeat (rows[r].ack_wait) @(negedge sd_clock);
				ack_in = 1'b1;
				@(negedge sd_clock);
				ack_in = 1'b0;
			end else begin
				// silent card with no timeout: abort after the window
				repeat (2 + `CMD_FRAME_BITS + `NCR_TIMEOUT + 16) @(negedge sd_clock);
				idle_in = 1'b1;
				@(negedge sd_clock);
				idle_in = 1'b0;
			end
			@(negedge sd_clock);
			test_end = 1'b1;
			@(negedge sd_clock);
			test_end = 1'b0;
			repeat (2) @(negedge sd_clock);
		end
		run_end = 1'b1;
		@(negedge sd_clock);
		run_end = 1'b0;
		@(negedge sd_clock);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/sd_cmd_pkg.sv
design/cmd_pad.sv
design/cmd_serializer.sv
design/cmd_deserializer.sv
design/cmd_phys_controller.sv
design/cmd_phys.sv
sim/sd_card_model.sv
sim/cmd_phys_monitor.sv
sim/cmd_phys_chk.sv
sim/cmd_phys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the command line testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module cmd_phys_tb -o cmd_phys_sim

output=$(./obj_dir/cmd_phys_sim)
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
	exit 0
else
	exit 1
fi
